/* isa_pkg.sv */
package isa_pkg;

  localparam int data_width = 16;  // Machine word

  // Opcode field, values outside the list decode as illegal
  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_xor = 4'd2,
    op_and = 4'd3,
    op_b   = 4'd12,
    op_br  = 4'd13
  } opcode_e;

  // Branch condition codes
  typedef enum logic [2:0] {
    cond_ne = 3'd0,
    cond_eq = 3'd1,
    cond_gt = 3'd2,
    cond_lt = 3'd3,
    cond_ge = 3'd4,
    cond_le = 3'd5,
    cond_ov = 3'd6,
    cond_un = 3'd7
  } cond_e;

  typedef struct packed {
    logic z;  // Result zero
    logic v;  // Signed overflow
    logic n;  // Result negative
  } flags_t;

  //////////////////////////////////////////////////////////////////////
  // Instruction word, register and branch formats share the opcode
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    opcode_e    opcode;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
  } instr_reg_t;

  typedef struct packed {
    opcode_e    opcode;
    cond_e      cond;
    logic [8:0] off;  // Halfword offset, BR takes rs from off[7:4]
  } instr_br_t;

  typedef union packed {
    instr_reg_t r;
    instr_br_t  b;
  } instr_u;

  // Decoded controls, decode to execute and state
  typedef struct packed {
    logic                  valid;
    logic                  illegal;
    logic                  is_load;    // Host register load
    opcode_e               op;
    cond_e                 cond;
    logic [8:0]            off;
    logic [3:0]            rd;         // Destination, or load index
    logic [data_width-1:0] load_data;
    logic                  is_br;      // Register-target branch
  } dec_ctrl_t;

  // Execute result, applied by state on the next edge
  typedef struct packed {
    logic                  valid;
    logic                  err;
    logic                  reg_we;
    logic [3:0]            rd;
    logic [data_width-1:0] wdata;
    flags_t                flag_we;  // Per-flag write mask
    flags_t                flags;
    logic [data_width-1:0] pc_next;
  } exec_res_t;

endpackage

/* bus_pkg.sv */
package bus_pkg;

  // AXI4-Lite channel payloads, valid/ready travel as plain wires
  typedef struct packed { logic [7:0] addr; } axil_aw_t;
  typedef struct packed { logic [31:0] data; } axil_w_t;
  typedef struct packed { logic [1:0] resp; } axil_b_t;
  typedef struct packed { logic [7:0] addr; } axil_ar_t;
  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } axil_r_t;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  //////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////
  localparam logic [7:0] addr_instr    = 8'h00;  // Write executes
  localparam logic [7:0] addr_pc       = 8'h00;  // Read only
  localparam logic [7:0] addr_flags    = 8'h04;  // Read only, z v n in 2:0
  localparam logic [7:0] addr_reg_base = 8'h40;  // rN at base + 4N

  typedef enum logic { kind_instr, kind_load } req_kind_e;

  // Read selection into the state block
  typedef enum logic [1:0] { sel_pc, sel_flags, sel_reg, sel_none } rd_sel_e;

  typedef struct packed {
    logic       valid;
    req_kind_e  kind;
    logic [15:0] word;  // Instruction word
    logic [3:0]  idx;   // Register index for loads
    logic [15:0] data;  // Load data
  } exec_req_t;

endpackage

/* axil_port.sv */
`timescale 1ns/1ps

module axil_port import bus_pkg::*, isa_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  axil_aw_t              aw,
  input  logic                  awvalid,
  output logic                  awready,
  input  axil_w_t               w,
  input  logic                  wvalid,
  output logic                  wready,
  output axil_b_t               b,
  output logic                  bvalid,
  input  logic                  bready,
  input  axil_ar_t              ar,
  input  logic                  arvalid,
  output logic                  arready,
  output axil_r_t               r,
  output logic                  rvalid,
  input  logic                  rready,
  output exec_req_t             req,
  input  exec_res_t             res,
  output logic [3:0]            rd_idx,
  output rd_sel_e               rd_sel,
  input  logic [data_width-1:0] rd_word
);

  logic        wr_go;        // Write handshake, cycle T
  logic        wr_pend;      // Request in flight, cycle T+1
  logic        wr_bad;       // Unmapped or read-only target
  logic        aw_is_instr;
  logic        aw_is_reg;
  logic        req_vld;
  req_kind_e   req_kind;
  logic [15:0] req_word;
  logic [3:0]  req_idx;
  logic [15:0] req_data;
  logic        ar_go;
  logic        rvalid_nxt;

  //////////////////////////////////////////////////////////////////////
  // Write channel
  //////////////////////////////////////////////////////////////////////
  assign aw_is_instr = (aw.addr == addr_instr);
  assign aw_is_reg   = (aw.addr[7:6] == addr_reg_base[7:6]) && (aw.addr[1:0] == 2'b00);

  assign awready = awvalid & wvalid & ~wr_pend & ~bvalid;  // Both channels at once
  assign wready  = awready;
  assign wr_go   = awready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_pend <= 1'b0;
      req_vld <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      wr_pend <= wr_go;
      req_vld <= wr_go & (aw_is_instr | aw_is_reg);  // Bad targets issue nothing
      if (wr_pend)     bvalid <= 1'b1;                 // Response at T+2
      else if (bready) bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_go) begin
      req_kind <= aw_is_instr ? kind_instr : kind_load;
      req_word <= w.data[15:0];
      req_idx  <= aw.addr[5:2];
      req_data <= w.data[15:0];  // Upper half dropped
      wr_bad   <= ~(aw_is_instr | aw_is_reg);
    end
    if (wr_pend) b.resp <= (wr_bad | res.err) ? resp_slverr : resp_okay;
  end

  assign req = '{valid: req_vld, kind: req_kind, word: req_word, idx: req_idx,
                 data: req_data};

  //////////////////////////////////////////////////////////////////////
  // Read channel
  //////////////////////////////////////////////////////////////////////
  assign rd_idx = ar.addr[5:2];

  always_comb begin
    if (ar.addr == addr_pc)                                                  rd_sel = sel_pc;
    else if (ar.addr == addr_flags)                                          rd_sel = sel_flags;
    else if (ar.addr[7:6] == addr_reg_base[7:6] && ar.addr[1:0] == 2'b00)  rd_sel = sel_reg;
    else                                                                     rd_sel = sel_none;
  end

  assign ar_go      = arvalid & arready;
  assign rvalid_nxt = rvalid ? ~rready : ar_go;  // Hold data until accepted

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid  <= 1'b0;
      arready <= 1'b0;
    end else begin
      rvalid  <= rvalid_nxt;
      arready <= ~rvalid_nxt;  // Open again once data has left
    end
  end

  always_ff @(posedge clk) begin
    if (ar_go) begin
      r.data <= {{(32-data_width){1'b0}}, rd_word};  // Zero for unmapped
      r.resp <= (rd_sel == sel_none) ? resp_slverr : resp_okay;
    end
  end

endmodule

/* instr_decode.sv */
`timescale 1ns/1ps

module instr_decode import isa_pkg::*, bus_pkg::*; (
  input  exec_req_t  req,
  output dec_ctrl_t  ctrl,
  output logic [3:0] rs_idx,
  output logic [3:0] rt_idx
);

  instr_u iw;       // Same word, two views
  logic   is_load;
  logic   is_alu;
  logic   is_bra;   // B or BR

  assign iw = req.word;

  always_comb begin
    is_load = (req.kind == kind_load);
    is_alu  = 1'b0;
    is_bra  = 1'b0;
    if (!is_load) begin
      case (iw.r.opcode)
        op_add, op_sub, op_xor, op_and: is_alu = 1'b1;
        op_b, op_br:                    is_bra = 1'b1;
        default:                        ;  // Left illegal
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Control fields
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    ctrl.valid     = req.valid;
    ctrl.illegal   = ~is_load & ~is_alu & ~is_bra;
    ctrl.is_load   = is_load;
    ctrl.op        = iw.r.opcode;
    ctrl.cond      = is_bra ? iw.b.cond : cond_ne;             // Branch view
    ctrl.off       = is_bra ? iw.b.off : 9'd0;
    ctrl.rd        = is_load ? req.idx : (is_alu ? iw.r.rd : 4'd0);  // Register view
    ctrl.load_data = req.data;
    ctrl.is_br     = is_bra && (iw.b.opcode == op_br);
  end

  // BR source off[7:4] overlays the rs field
  assign rs_idx = iw.r.rs;
  assign rt_idx = iw.r.rt;

endmodule

/* branch_control.sv */
`timescale 1ns/1ps

module branch_control import isa_pkg::*; (
  input  cond_e                 cond,
  input  logic [8:0]            off,
  input  flags_t                flags,
  input  logic [data_width-1:0] rs_val,
  input  logic                  is_branch,
  input  logic                  is_br,
  input  logic [data_width-1:0] pc_seq,   // pc+2
  output logic                  taken,
  output logic [data_width-1:0] target
);

  logic                  cond_met;
  logic [data_width-1:0] off_ext;  // Sign extended, halfword scaled

  always_comb begin
    case (cond)
      cond_ne: cond_met = ~flags.z;
      cond_eq: cond_met = flags.z;
      cond_gt: cond_met = ~flags.z & ~flags.n;
      cond_lt: cond_met = flags.n;
      cond_ge: cond_met = flags.z | (~flags.z & ~flags.n);
      cond_le: cond_met = flags.z | flags.n;
      cond_ov: cond_met = flags.v;
      default: cond_met = 1'b1;  // UN
    endcase
  end

  assign taken   = is_branch & cond_met;
  assign off_ext = {{(data_width-10){off[8]}}, off, 1'b0};
  assign target  = is_br ? rs_val : pc_seq + off_ext;  // BR jumps to rs

endmodule

/* exec_unit.sv */
`timescale 1ns/1ps

module exec_unit import isa_pkg::*; (
  input  dec_ctrl_t             ctrl,
  input  logic [data_width-1:0] rs_val,
  input  logic [data_width-1:0] rt_val,
  input  logic [data_width-1:0] pc,
  input  flags_t                flags,
  output exec_res_t             res
);

  logic [data_width-1:0] pc_seq;
  logic [data_width-1:0] target;
  logic [data_width-1:0] alu_out;
  logic                  ovf;
  logic                  taken;
  logic                  is_branch;
  logic                  is_alu;
  flags_t                alu_flags;
  flags_t                alu_mask;   // Flags this op may write

  assign pc_seq    = pc + 16'd2;
  assign is_branch = ctrl.valid & ~ctrl.illegal & ~ctrl.is_load &
                     (ctrl.op == op_b || ctrl.op == op_br);
  assign is_alu    = ctrl.valid & ~ctrl.illegal & ~ctrl.is_load & ~is_branch;

  branch_control i_branch (
    .cond      (ctrl.cond),
    .off       (ctrl.off),
    .flags     (flags),
    .rs_val    (rs_val),
    .is_branch (is_branch),
    .is_br     (ctrl.is_br),
    .pc_seq    (pc_seq),
    .taken     (taken),
    .target    (target)
  );

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    alu_out  = '0;
    ovf      = 1'b0;
    alu_mask = '{z: 1'b0, v: 1'b0, n: 1'b0};
    case (ctrl.op)
      op_add: begin
        alu_out  = rs_val + rt_val;
        ovf      = (rs_val[15] == rt_val[15]) && (alu_out[15] != rs_val[15]);
        alu_mask = '{z: 1'b1, v: 1'b1, n: 1'b1};
      end
      op_sub: begin
        alu_out  = rs_val - rt_val;
        ovf      = (rs_val[15] != rt_val[15]) && (alu_out[15] != rs_val[15]);
        alu_mask = '{z: 1'b1, v: 1'b1, n: 1'b1};
      end
      op_xor: begin
        alu_out  = rs_val ^ rt_val;
        alu_mask = '{z: 1'b1, v: 1'b0, n: 1'b0};  // Logic ops touch z only
      end
      op_and: begin
        alu_out  = rs_val & rt_val;
        alu_mask = '{z: 1'b1, v: 1'b0, n: 1'b0};
      end
      default: ;
    endcase
    alu_flags = '{z: (alu_out == '0), v: ovf, n: alu_out[15]};
  end

  always_comb begin
    res.valid   = ctrl.valid;
    res.err     = ctrl.valid & ctrl.illegal;
    res.reg_we  = is_alu | (ctrl.valid & ctrl.is_load);
    res.rd      = ctrl.rd;
    res.wdata   = ctrl.is_load ? ctrl.load_data : alu_out;
    res.flag_we = alu_mask;
    if (!is_alu) res.flag_we = '{z: 1'b0, v: 1'b0, n: 1'b0};
    res.flags   = alu_flags;
    // Loads and illegal words keep the PC
    res.pc_next = (ctrl.is_load | ctrl.illegal) ? pc : (taken ? target : pc_seq);
  end

endmodule

/* arch_state.sv */
`timescale 1ns/1ps

module arch_state import isa_pkg::*, bus_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  exec_res_t             res,
  input  logic [3:0]            rs_idx,
  input  logic [3:0]            rt_idx,
  output logic [data_width-1:0] rs_val,
  output logic [data_width-1:0] rt_val,
  output logic [data_width-1:0] pc,
  output flags_t                flags,
  input  rd_sel_e               rd_sel,
  input  logic [3:0]            rd_idx,
  output logic [data_width-1:0] rd_word
);

  logic [data_width-1:0] regs [16];  // r0 never written

  //////////////////////////////////////////////////////////////////////
  // State update
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regs  <= '{default: '0};
      pc    <= '0;
      flags <= '{z: 1'b0, v: 1'b0, n: 1'b0};
    end else if (res.valid) begin
      if (res.reg_we && res.rd != 4'd0) begin
        regs[res.rd] <= res.wdata;
      end
      flags <= (flags & ~res.flag_we) | (res.flags & res.flag_we);  // Masked merge
      pc    <= res.pc_next;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////////////////////////
  assign rs_val = regs[rs_idx];  // Execute operands
  assign rt_val = regs[rt_idx];

  // Host read port, sampled by the bus in the address cycle
  always_comb begin
    case (rd_sel)
      sel_pc:    rd_word = pc;
      sel_flags: rd_word = {{(data_width-3){1'b0}}, flags};
      sel_reg:   rd_word = regs[rd_idx];
      default:   rd_word = '0;
    endcase
  end

endmodule

/* core_top.sv */
`timescale 1ns/1ps

module core_top import bus_pkg::*, isa_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  axil_aw_t aw,
  input  logic     awvalid,
  output logic     awready,
  input  axil_w_t  w,
  input  logic     wvalid,
  output logic     wready,
  output axil_b_t  b,
  output logic     bvalid,
  input  logic     bready,
  input  axil_ar_t ar,
  input  logic     arvalid,
  output logic     arready,
  output axil_r_t  r,
  output logic     rvalid,
  input  logic     rready
);

  exec_req_t             req;
  dec_ctrl_t             ctrl;
  exec_res_t             res;
  logic [3:0]            rs_idx;
  logic [3:0]            rt_idx;
  logic [data_width-1:0] rs_val;
  logic [data_width-1:0] rt_val;
  logic [data_width-1:0] pc;
  flags_t                flags;
  logic [3:0]            rd_idx;
  rd_sel_e               rd_sel;
  logic [data_width-1:0] rd_word;

  // Bus slave, issues one request per accepted write
  axil_port i_port (
    .clk (clk), .rst_n (rst_n),
    .aw (aw), .awvalid (awvalid), .awready (awready),
    .w (w), .wvalid (wvalid), .wready (wready),
    .b (b), .bvalid (bvalid), .bready (bready),
    .ar (ar), .arvalid (arvalid), .arready (arready),
    .r (r), .rvalid (rvalid), .rready (rready),
    .req (req), .res (res),
    .rd_idx (rd_idx), .rd_sel (rd_sel), .rd_word (rd_word)
  );

  instr_decode i_decode (
    .req (req), .ctrl (ctrl), .rs_idx (rs_idx), .rt_idx (rt_idx)
  );

  exec_unit i_exec (
    .ctrl (ctrl), .rs_val (rs_val), .rt_val (rt_val),
    .pc (pc), .flags (flags), .res (res)
  );

  arch_state i_state (
    .clk (clk), .rst_n (rst_n), .res (res),
    .rs_idx (rs_idx), .rt_idx (rt_idx), .rs_val (rs_val), .rt_val (rt_val),
    .pc (pc), .flags (flags),
    .rd_sel (rd_sel), .rd_idx (rd_idx), .rd_word (rd_word)
  );

endmodule

/* core_chk.sv */
`timescale 1ns/1ps

module core_chk import bus_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  input logic    awready,
  input logic    wready,
  input logic    arready,
  input logic    bvalid,
  input logic    bready,
  input axil_b_t b,
  input logic    rvalid,
  input logic    rready,
  input axil_r_t r
);

  //////////////////////////////////////////////////////////////////////
  // Response channels hold until the host takes them
  //////////////////////////////////////////////////////////////////////
  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(b))
    else $error("b channel changed while bready was low");

  r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(r))
    else $error("r channel changed while rready was low");

  // Address and data are always accepted in the same cycle
  aw_w_pair: assert property (@(posedge clk) disable iff (!rst_n) awready == wready)
    else $error("awready and wready differ");

  //////////////////////////////////////////////////////////////////////
  // Reset state
  //////////////////////////////////////////////////////////////////////
  in_reset: assert property (@(posedge clk) !rst_n |-> !bvalid && !rvalid && !arready)
    else $error("Handshake outputs active during reset");

  after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !bvalid && !rvalid)
    else $error("Valid high in the first cycle after reset");

endmodule

/* tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // Reset held for the first 10 rising edges
  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* tb_core.sv */
`timescale 1ns/1ps

module tb_core import bus_pkg::*; ();

  logic     clk;
  logic     rst_n;
  axil_aw_t aw;
  logic     awvalid;
  logic     awready;
  axil_w_t  w;
  logic     wvalid;
  logic     wready;
  axil_b_t  b;
  logic     bvalid;
  logic     bready;
  axil_ar_t ar;
  logic     arvalid;
  logic     arready;
  axil_r_t  r;
  logic     rvalid;
  logic     rready;

  byte unsigned tr_kind [$];  // 'W' or 'R'
  logic [7:0]   tr_addr [$];
  logic [31:0]  tr_data [$];  // Write data, or expected read data
  logic [1:0]   tr_resp [$];  // Expected response code
  logic [31:0]  lcg_state;
  bit           trace_loaded;

  tb_clkgen i_clkgen (.clk (clk), .rst_n (rst_n));

  core_top i_dut (
    .clk (clk), .rst_n (rst_n),
    .aw (aw), .awvalid (awvalid), .awready (awready),
    .w (w), .wvalid (wvalid), .wready (wready),
    .b (b), .bvalid (bvalid), .bready (bready),
    .ar (ar), .arvalid (arvalid), .arready (arready),
    .r (r), .rvalid (rvalid), .rready (rready)
  );

  bind core_top core_chk i_chk (
    .clk (clk), .rst_n (rst_n), .awready (awready), .wready (wready),
    .arready (arready), .bvalid (bvalid), .bready (bready), .b (b),
    .rvalid (rvalid), .rready (rready), .r (r)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////
  // LCG step, stall length 0 to 3 from the middle bits
  function automatic logic [1:0] next_stall();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[17:16];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  // Trace lines are kind, addr, data, resp; '#' starts a comment line
  task automatic load_trace();
    int          fd;
    string       line;
    logic [7:0]  addr;
    logic [31:0] data;
    logic [1:0]  resp;
    fd = $fopen("core_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the trace file core_trace.txt");
      $display("Verification failed");
      $fatal(1);
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;  // Blank or comment
      if (line[0] != "W" && line[0] != "R") begin
        $display("Trace line has an unknown kind: %s", line);
        $display("Verification failed");
        $fatal(1);
      end
      void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", addr, data, resp));
      tr_kind.push_back(line[0]);
      tr_addr.push_back(addr);
      tr_data.push_back(data);
      tr_resp.push_back(resp);
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus transactions, driven on rising edges and sampled on falling ones
  //////////////////////////////////////////////////////////////////////
  task automatic write_word(input logic [7:0] addr, input logic [31:0] data,
                            input logic [1:0] exp_resp);
    int unsigned stall;
    @(posedge clk);
    aw.addr <= addr;
    w.data  <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    do @(negedge clk); while (!awready);  // Accepted at the next edge
    check_value("wready", {31'd0, wready}, 32'd1);
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    do @(negedge clk); while (!bvalid);
    stall = next_stall();
    repeat (stall) @(posedge clk);  // Response must hold meanwhile
    @(posedge clk);
    bready <= 1'b1;
    @(negedge clk);
    check_value("bvalid", {31'd0, bvalid}, 32'd1);
    check_value("bresp", {30'd0, b.resp}, {30'd0, exp_resp});
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic read_word(input logic [7:0] addr, input logic [31:0] exp_data,
                           input logic [1:0] exp_resp);
    int unsigned stall;
    @(posedge clk);
    ar.addr <= addr;
    arvalid <= 1'b1;
    do @(negedge clk); while (!arready);
    @(posedge clk);
    arvalid <= 1'b0;
    do @(negedge clk); while (!rvalid);
    stall = next_stall();
    repeat (stall) @(posedge clk);
    @(posedge clk);
    rready <= 1'b1;
    @(negedge clk);
    check_value("rvalid", {31'd0, rvalid}, 32'd1);
    check_value("rdata", r.data, exp_data);
    check_value("rresp", {30'd0, r.resp}, {30'd0, exp_resp});
    @(posedge clk);
    rready <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    aw      = '0;
    w       = '0;
    ar      = '0;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;
    bready  = 1'b0;
    rready  = 1'b0;
    lcg_state    = 32'hf41c;
    trace_loaded = 1'b0;
    load_trace();
    trace_loaded = 1'b1;
    @(posedge rst_n);
    for (int i = 0; i < tr_kind.size(); i++) begin
      if (tr_kind[i] == "W") write_word(tr_addr[i], tr_data[i], tr_resp[i]);
      else                   read_word(tr_addr[i], tr_data[i], tr_resp[i]);
    end
    repeat (4) @(posedge clk);  // Let the checker see the idle bus
    $display("Verification passed");
    $finish;
  end

  // Watchdog, 40 cycles per trace entry plus reset
  initial begin
    int limit;
    wait (trace_loaded);
    limit = tr_kind.size() * 40 + 20;
    repeat (limit) @(posedge clk);
    $display("Timeout: the DUT did not finish the trace within %0d cycles", limit);
    $display("Verification failed");
    $fatal(1);
  end

endmodule

/* core_trace.txt */
# Columns: kind addr data resp, all hex; resp 0 is OKAY, 2 is SLVERR
# W writes data and expects resp; R expects data and resp back
# Register loads, upper half dropped, r0 stays zero
W 44 abcd1234 0
W 48 00007fff 0
W 4c 00000001 0
W 40 00005555 0
R 40 00000000 0
R 44 00001234 0
# ALU ops
W 00 00000423 0
R 50 00008000 0
R 04 00000003 0
W 00 00002613 0
W 00 00003710 0
R 04 00000007 0
R 58 00001235 0
W 00 00001511 0
R 04 00000004 0
# Branches with z set
W 00 0000c205 0
W 00 0000c005 0
W 00 0000c401 0
W 00 0000c802 0
R 00 0000001e 0
W 00 0000cbfc 0
W 00 0000c603 0
W 00 0000cc03 0
W 00 0000cffd 0
R 00 00000018 0
# Branches with n set
W 00 00000843 0
R 04 00000001 0
W 00 0000c602 0
W 00 0000c402 0
R 00 00000022 0
W 00 0000de10 0
R 00 00001234 0
# Error cases leave state alone
W 00 00007123 2
W 04 00000000 2
W 20 00000001 2
W 41 00000009 2
R 00 00001234 0
R 44 00001234 0
R 60 00008001 0
R 04 00000001 0
R 20 00000000 2

/* files.f */
isa_pkg.sv
bus_pkg.sv
axil_port.sv
instr_decode.sv
branch_control.sv
exec_unit.sv
arch_state.sv
core_top.sv
core_chk.sv
tb_clkgen.sv
tb_core.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_core \
		-f files.f --Mdir obj_dir -o sim_core

run: compile
	@out=$$(./obj_dir/sim_core); echo "$$out"; \
		echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
